//--- src.f
+incdir+include
design/hba_pkg.sv
design/serial_uart.sv
design/hba_master.sv
design/hba_reg_bank.sv
design/hba_read_combiner.sv
design/serial_bridge.sv
design/serial_fpga.sv
testbench/tb_serial_fpga.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the serial bridge testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_serial_fpga -o sim_tb
output=$(./obj_dir/sim_tb)
echo "$output"

if grep -qx "All tests passed" <<< "$output"; then
   exit 0
else
   echo "Simulation did not report a pass"
   exit 1
fi

//--- testbench/tb_serial_fpga.sv
// Testbench for the serial to HBA bridge with a serial host model and a register model
`include "serial_fpga_consts.svh"

module tb_serial_fpga;
   localparam int CPB        = `SERIAL_CLKS_PER_BIT;
   localparam int WAIT_LIMIT = 40 * CPB;   // Cycles allowed for any one wait

   logic hba_clk, hba_reset, rxd, cts;
   logic txd, rts;

   logic [7:0] model [`HBA_NUM_PERIPH][`HBA_NUM_REGS];   // Expected bank contents
   int errors, test_errors;                               // Total and per-test mismatches
   int tests_run, tests_bad;

   serial_fpga i_serial_fpga (.hba_clk, .hba_reset, .rxd, .cts, .txd, .rts);

   initial begin
      hba_clk = 1'b0;
      forever #10 hba_clk = ~hba_clk;
   end

   task automatic give_up(input string what);
      $display("TIMEOUT at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
      $display("Some tests failed");
      $finish;
   endtask

   task automatic check_level(input string name, input logic got, input logic expected);
      if (got !== expected) begin
         $display("ERROR %0t %s: got %b, expected %b", $time, name, got, expected);
         test_errors++;
      end
   endtask

   task automatic wait_for_rts();
      int n;
      n = 0;
      while (!rts) begin   // Bridge back in IDLE
         if (n == WAIT_LIMIT) give_up("rts rising");
         @(negedge hba_clk);
         n++;
      end
   endtask

   // Host side frame on rxd, starts and ends on a falling edge
   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};   // Stop, data, start
      for (int i = 0; i < 10; i++) begin
         rxd = frame[i];
         repeat (CPB) @(negedge hba_clk);
      end
   endtask

   // Samples txd at mid-bit, returns in the middle of the stop bit
   task automatic receive_byte(output logic [7:0] b);
      int n;
      n = 0;
      while (txd) begin
         if (n == WAIT_LIMIT) give_up("start bit on txd");
         @(negedge hba_clk);
         n++;
      end
      repeat (CPB / 2) @(negedge hba_clk);
      check_level("txd start bit", txd, 1'b0);
      for (int i = 0; i < 8; i++) begin
         repeat (CPB) @(negedge hba_clk);
         b[i] = txd;   // LSB first
      end
      repeat (CPB) @(negedge hba_clk);
      check_level("txd stop bit", txd, 1'b1);
   endtask

   // Keeps cts low and watches txd stay idle, then releases cts
   task automatic hold_cts_low(input int cycles);
      int low_cycles;
      low_cycles = 0;
      for (int i = 0; i < cycles; i++) begin
         @(negedge hba_clk);
         if (!txd) low_cycles++;
      end
      if (low_cycles != 0) begin
         $display("Start bit sent on txd while cts was low, at %0t", $time);
         test_errors++;
      end
      cts = 1'b1;
   endtask

   task automatic run_command(input bit rnw, input int count, input int bank,
                              input int start, input bit stall);
      logic [7:0] cmd, addr, data;
      int r;
      cmd  = {2'($urandom), 2'(bank), 3'(count - 1), rnw};   // Bits 7:6 are noise
      addr = {4'($urandom), 4'(start)};                      // So is the upper nibble
      if (stall) cts = 1'b0;
      send_byte(cmd);
      send_byte(addr);
      check_level("rts", rts, 1'b0);   // Busy with the command
      for (int i = 0; i < count; i++) begin
         r = (start + i) % `HBA_NUM_REGS;   // Wraps in the bank
         if (rnw) begin
            if (stall) hold_cts_low(20 + $urandom % 100);
            receive_byte(data);
            if (stall && i < count - 1) cts = 1'b0;   // Stop bit still on the line
            if (data !== model[bank][r]) begin
               $display("ERROR %0t txd data bank %0d reg %0d: got %02h, expected %02h",
                        $time, bank, r, data, model[bank][r]);
               test_errors++;
            end
         end else begin
            data = 8'($urandom);
            send_byte(data);
            model[bank][r] = data;
         end
      end
      wait_for_rts();
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors != 0) tests_bad++;
      errors += test_errors;
      $display("Test %0d %s: %s, %0d errors", tests_run, name,
               (test_errors == 0) ? "ok" : "FAIL", test_errors);
      test_errors = 0;
   endtask

   initial begin
      int b, r;
      void'($urandom(56166));   // One seed for the whole run
      errors = 0;
      test_errors = 0;
      tests_run = 0;
      tests_bad = 0;
      rxd = 1'b1;   // Idle line
      cts = 1'b1;
      hba_reset = 1'b1;
      for (int i = 0; i < `HBA_NUM_PERIPH; i++) begin
         for (int j = 0; j < `HBA_NUM_REGS; j++) model[i][j] = 8'h00;   // Banks clear on reset
      end

      repeat (5) begin
         @(negedge hba_clk);
         check_level("txd", txd, 1'b1);
         check_level("rts", rts, 1'b0);
      end
      hba_reset = 1'b0;
      wait_for_rts();
      check_level("txd", txd, 1'b1);
      finish_test("reset and idle lines");

      for (b = 0; b < `HBA_NUM_PERIPH; b++) begin
         r = $urandom % `HBA_NUM_REGS;
         run_command(1'b1, 1, b, (r + 5) % `HBA_NUM_REGS, 1'b0);   // Untouched, reads zero
         run_command(1'b0, 1, b, r, 1'b0);
         run_command(1'b1, 1, b, r, 1'b0);
      end
      finish_test("single-byte write and read per bank");

      b = $urandom % `HBA_NUM_PERIPH;
      run_command(1'b0, 8, b, 12, 1'b0);   // Registers 12..15 then 0..3
      run_command(1'b1, 8, b, 12, 1'b0);
      finish_test("burst with register wrap");

      repeat (40) begin
         run_command(1'($urandom), 1 + $urandom % 8, $urandom % `HBA_NUM_PERIPH,
                     $urandom % `HBA_NUM_REGS, 1'b0);
      end
      finish_test("random commands");

      repeat (3) begin
         run_command(1'b1, 1 + $urandom % 8, $urandom % `HBA_NUM_PERIPH,
                     $urandom % `HBA_NUM_REGS, 1'b1);
      end
      finish_test("reads stalled by cts");

      $display("Summary: %0d tests run, %0d with errors, %0d errors in total",
               tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- design/serial_fpga.sv
// Serial to HBA bridge top level with UART, command parser, bus master and register banks
`include "serial_fpga_consts.svh"

module serial_fpga (
   input  logic hba_clk,
   input  logic hba_reset,
   input  logic rxd,
   input  logic cts,
   output logic txd,
   output logic rts
);
   import hba_pkg::*;

   hba_data_t rx_data, tx_data;
   logic      rx_valid, tx_start, tx_busy;
   hba_addr_t app_addr;                      // Bridge to master
   hba_data_t app_data_in, app_data_out;
   logic      app_rnw, app_strobe, app_valid;
   logic      master_request, hba_mgrant;
   hba_addr_t master_abus;                   // Shared bus, master side
   hba_data_t master_dbus;
   logic      master_rnw, master_select;
   hba_data_t [`HBA_NUM_PERIPH-1:0] bank_dbus;
   logic [`HBA_NUM_PERIPH-1:0]      bank_xferack;
   hba_data_t hba_dbus;                      // Combined return bus
   logic      hba_xferack;

   serial_uart i_serial_uart (
      .hba_clk, .hba_reset, .rxd, .txd, .tx_data, .tx_start, .tx_busy, .rx_data, .rx_valid
   );

   serial_bridge i_serial_bridge (
      .hba_clk, .hba_reset, .rx_data, .rx_valid, .tx_data, .tx_start, .tx_busy, .cts, .rts,
      .app_addr, .app_data_in, .app_rnw, .app_strobe, .app_data_out, .app_valid,
      .master_request, .hba_mgrant
   );

   hba_master i_hba_master (
      .hba_clk, .hba_reset, .app_addr, .app_data_in, .app_rnw, .app_strobe, .app_data_out,
      .app_valid, .hba_mgrant, .hba_xferack, .hba_dbus, .master_request, .master_abus,
      .master_rnw, .master_select, .master_dbus
   );

   for (genvar g = 0; g < `HBA_NUM_PERIPH; g++) begin : g_bank
      hba_reg_bank #(.PERIPH_INDEX(hba_periph_t'(g))) i_hba_reg_bank (
         .hba_clk, .hba_reset, .master_abus, .master_rnw, .master_select, .master_dbus,
         .bank_dbus(bank_dbus[g]),
         .bank_xferack(bank_xferack[g])
      );
   end

   hba_read_combiner i_hba_read_combiner (
      .bank_dbus, .bank_xferack, .hba_dbus, .hba_xferack
   );

endmodule

//--- design/serial_bridge.sv
// Command parser that turns host serial commands into HBA bus transfers and sends read data back
`include "serial_fpga_consts.svh"

module serial_bridge (
   input  logic               hba_clk,
   input  logic               hba_reset,
   input  hba_pkg::hba_data_t rx_data,
   input  logic               rx_valid,
   output hba_pkg::hba_data_t tx_data,
   output logic               tx_start,
   input  logic               tx_busy,
   input  logic               cts,            // Low holds back transmission
   output logic               rts,            // High only while idle
   output hba_pkg::hba_addr_t app_addr,
   output hba_pkg::hba_data_t app_data_in,
   output logic               app_rnw,
   output logic               app_strobe,
   input  hba_pkg::hba_data_t app_data_out,
   input  logic               app_valid,
   input  logic               master_request,
   output logic               hba_mgrant
);
   import hba_pkg::*;

   bridge_state_t state;
   logic          cmd_rnw;     // Read flag of the current command
   hba_periph_t   periph;      // Target bank
   hba_reg_t      reg_idx;     // Current register, wraps in the bank
   logic [2:0]    remaining;   // Bytes left after the current one

   // Single master, so the grant just follows the request a cycle later
   always_ff @(posedge hba_clk) begin
      if (hba_reset) hba_mgrant <= 1'b0;
      else hba_mgrant <= master_request;
   end

   always_ff @(posedge hba_clk) begin
      if (hba_reset) begin
         state      <= IDLE;
         rts        <= 1'b0;
         tx_start   <= 1'b0;
         app_strobe <= 1'b0;
         cmd_rnw    <= 1'b0;
         periph     <= '0;
         reg_idx    <= '0;
         remaining  <= '0;
      end else begin
         tx_start   <= 1'b0;
         app_strobe <= 1'b0;
         rts        <= 1'b0;
         case (state)
            IDLE: begin
               rts <= !rx_valid;   // Drop at once when a command byte lands
               if (rx_valid) begin
                  cmd_rnw   <= rx_data[0];
                  remaining <= rx_data[3:1];   // Count minus one
                  periph    <= rx_data[5:4];   // Bits 7:6 ignored
                  state     <= GET_ADDR;
               end
            end
            GET_ADDR: if (rx_valid) begin
               reg_idx <= rx_data[`HBA_REG_ADDR_WIDTH-1:0];   // Upper nibble ignored
               if (cmd_rnw) begin   // Reads go straight to the bus
                  app_addr   <= {periph, rx_data[`HBA_REG_ADDR_WIDTH-1:0]};
                  app_rnw    <= 1'b1;
                  app_strobe <= 1'b1;
                  state      <= BUS_XFER;
               end else state <= WRITE_DATA;
            end
            WRITE_DATA: if (rx_valid) begin
               app_addr    <= {periph, reg_idx};
               app_data_in <= rx_data;
               app_rnw     <= 1'b0;
               app_strobe  <= 1'b1;
               state       <= BUS_XFER;
            end
            BUS_XFER: if (app_valid) begin
               reg_idx <= reg_idx + 1'b1;   // Wraps within 16 registers
               if (cmd_rnw) begin
                  tx_data <= app_data_out;
                  state   <= SEND_DATA;
               end else if (remaining == 0) begin
                  rts   <= 1'b1;
                  state <= IDLE;
               end else begin
                  remaining <= remaining - 3'd1;
                  state     <= WRITE_DATA;
               end
            end
            SEND_DATA: if (cts && !tx_busy) begin   // Stalls here while cts low
               tx_start <= 1'b1;
               state    <= SEND_WAIT;
            end
            SEND_WAIT: if (!tx_start && !tx_busy) begin   // Busy rises a cycle after start
               if (remaining == 0) begin
                  rts   <= 1'b1;
                  state <= IDLE;
               end else begin
                  remaining  <= remaining - 3'd1;
                  app_addr   <= {periph, reg_idx};
                  app_rnw    <= 1'b1;
                  app_strobe <= 1'b1;
                  state      <= BUS_XFER;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // The master answers only a transfer in flight, never in the strobe cycle
   a_valid_in_xfer: assert property (@(posedge hba_clk) disable iff (hba_reset)
      app_valid |-> (state == BUS_XFER && !app_strobe));

endmodule

//--- design/hba_read_combiner.sv
// OR combiner that merges bank read data and acks onto the shared HBA return bus
`include "serial_fpga_consts.svh"

module hba_read_combiner (
   input  hba_pkg::hba_data_t [`HBA_NUM_PERIPH-1:0] bank_dbus,
   input  logic [`HBA_NUM_PERIPH-1:0]               bank_xferack,
   output hba_pkg::hba_data_t                       hba_dbus,
   output logic                                     hba_xferack
);
   import hba_pkg::*;

   always_comb begin
      hba_data_t acc;   // Idle banks drive zero, so OR is enough
      acc = '0;
      for (int i = 0; i < `HBA_NUM_PERIPH; i++) acc |= bank_dbus[i];
      hba_dbus    = acc;
      hba_xferack = |bank_xferack;
      // Decoding keeps the banks exclusive
      a_one_ack: assert ($isunknown(bank_xferack) || $onehot0(bank_xferack));
   end

endmodule

//--- design/hba_reg_bank.sv
// HBA register-bank peripheral, 16 byte registers answering one peripheral index
`include "serial_fpga_consts.svh"

module hba_reg_bank #(
   parameter hba_pkg::hba_periph_t PERIPH_INDEX = '0
) (
   input  logic               hba_clk,
   input  logic               hba_reset,
   input  hba_pkg::hba_addr_t master_abus,
   input  logic               master_rnw,
   input  logic               master_select,
   input  hba_pkg::hba_data_t master_dbus,
   output hba_pkg::hba_data_t bank_dbus,     // Read data, zero outside the ack cycle
   output logic               bank_xferack
);
   import hba_pkg::*;

   hba_data_t   regs [`HBA_NUM_REGS];
   hba_periph_t sel_periph;
   hba_reg_t    sel_reg;
   logic        hit;
   logic        done;   // Acked this select already

   assign sel_periph = master_abus[`HBA_ADDR_WIDTH-1 -: `HBA_PERIPH_ADDR_WIDTH];
   assign sel_reg    = master_abus[`HBA_REG_ADDR_WIDTH-1:0];
   assign hit        = master_select && (sel_periph == PERIPH_INDEX) && !done;

   always_ff @(posedge hba_clk) begin
      if (hba_reset) begin
         for (int i = 0; i < `HBA_NUM_REGS; i++) regs[i] <= '0;
         bank_dbus    <= '0;
         bank_xferack <= 1'b0;
         done         <= 1'b0;
      end else begin
         bank_xferack <= hit;   // Single ack cycle per select
         bank_dbus    <= (hit && master_rnw) ? regs[sel_reg] : '0;
         if (hit && !master_rnw) regs[sel_reg] <= master_dbus;
         if (!master_select) done <= 1'b0;   // Rearm when select drops
         else if (hit) done <= 1'b1;
      end
   end

endmodule

//--- design/hba_master.sv
// HBA bus master running one request, grant, select and ack transfer per application strobe
module hba_master (
   input  logic               hba_clk,
   input  logic               hba_reset,
   input  hba_pkg::hba_addr_t app_addr,
   input  hba_pkg::hba_data_t app_data_in,
   input  logic               app_rnw,
   input  logic               app_strobe,
   output hba_pkg::hba_data_t app_data_out,
   output logic               app_valid,
   input  logic               hba_mgrant,
   input  logic               hba_xferack,
   input  hba_pkg::hba_data_t hba_dbus,
   output logic               master_request,
   output hba_pkg::hba_addr_t master_abus,    // Zero while not selected
   output logic               master_rnw,
   output logic               master_select,
   output hba_pkg::hba_data_t master_dbus     // Write data, zero while not selected
);
   import hba_pkg::*;

   typedef enum logic [1:0] {M_IDLE, M_REQ, M_XFER} master_state_t;

   master_state_t m_state;
   hba_addr_t     addr_q;    // Transfer held from the strobe
   hba_data_t     data_q;
   logic          rnw_q;

   always_ff @(posedge hba_clk) begin
      if (hba_reset) begin
         m_state        <= M_IDLE;
         master_request <= 1'b0;
         master_select  <= 1'b0;
         master_abus    <= '0;
         master_dbus    <= '0;
         master_rnw     <= 1'b1;
         app_valid      <= 1'b0;
      end else begin
         app_valid <= 1'b0;
         case (m_state)
            M_IDLE: if (app_strobe) begin
               addr_q         <= app_addr;
               data_q         <= app_data_in;
               rnw_q          <= app_rnw;
               master_request <= 1'b1;
               m_state        <= M_REQ;
            end
            M_REQ: if (hba_mgrant) begin   // Drive the bus once granted
               master_select <= 1'b1;
               master_abus   <= addr_q;
               master_rnw    <= rnw_q;
               master_dbus   <= rnw_q ? '0 : data_q;
               m_state       <= M_XFER;
            end
            M_XFER: if (hba_xferack) begin
               app_data_out   <= hba_dbus;   // Only meaningful on a read
               app_valid      <= 1'b1;
               master_request <= 1'b0;
               master_select  <= 1'b0;
               master_abus    <= '0;
               master_dbus    <= '0;
               m_state        <= M_IDLE;
            end
            default: m_state <= M_IDLE;
         endcase
      end
   end

   // A strobe that arrives mid-transfer would be lost
   a_strobe_when_idle: assert property (@(posedge hba_clk) disable iff (hba_reset)
      app_strobe |-> m_state == M_IDLE);

endmodule

//--- design/serial_uart.sv
// Serial byte receiver and transmitter, 8N1, with a fixed bit-period divider
`include "serial_fpga_consts.svh"

module serial_uart (
   input  logic               hba_clk,
   input  logic               hba_reset,
   input  logic               rxd,
   output logic               txd,
   input  hba_pkg::hba_data_t tx_data,
   input  logic               tx_start,   // One-cycle pulse, only while idle
   output logic               tx_busy,
   output hba_pkg::hba_data_t rx_data,
   output logic               rx_valid    // One-cycle pulse per byte
);
   localparam int CPB   = `SERIAL_CLKS_PER_BIT;
   localparam int CNT_W = $clog2(CPB) + 1;
   localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CPB / 2 - 1); // Start edge to mid-bit
   localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CPB - 1);
   localparam logic [1:0] RX_IDLE = 2'd0, RX_START = 2'd1, RX_DATA = 2'd2, RX_STOP = 2'd3;

   logic [1:0]       rx_sync;    // Metastability stages, idle high
   logic [1:0]       rx_state;
   logic [CNT_W-1:0] rx_cnt;
   logic [2:0]       rx_bit;
   logic [7:0]       rx_shift;
   logic [CNT_W-1:0] tx_cnt;
   logic [3:0]       tx_bits;    // Bit periods left after this one
   logic [9:0]       tx_shift;   // Stop, data, start; LSB is on the line

   assign txd = tx_shift[0];

   always_ff @(posedge hba_clk) begin
      if (hba_reset) begin
         rx_sync  <= 2'b11;
         rx_state <= RX_IDLE;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_sync  <= {rx_sync[0], rxd};
         rx_valid <= 1'b0;
         case (rx_state)
            RX_IDLE: if (!rx_sync[1]) begin  // Falling edge, maybe a start bit
               rx_cnt   <= HALF_BIT;
               rx_state <= RX_START;
            end
            RX_START: if (rx_cnt == 0) begin
               rx_cnt   <= FULL_BIT;
               rx_bit   <= '0;
               rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;  // High again means a glitch
            end else rx_cnt <= rx_cnt - 1'b1;
            RX_DATA: if (rx_cnt == 0) begin
               rx_shift <= {rx_sync[1], rx_shift[7:1]};    // LSB arrives first
               rx_cnt   <= FULL_BIT;
               rx_bit   <= rx_bit + 1'b1;
               if (rx_bit == 3'd7) rx_state <= RX_STOP;
            end else rx_cnt <= rx_cnt - 1'b1;
            default: if (rx_cnt == 0) begin                // Mid stop bit
               rx_valid <= rx_sync[1];                    // Framing error drops the byte
               rx_data  <= rx_shift;
               rx_state <= RX_IDLE;
            end else rx_cnt <= rx_cnt - 1'b1;
         endcase
      end
   end

   always_ff @(posedge hba_clk) begin
      if (hba_reset) begin
         tx_shift <= '1;   // Line idles high
         tx_busy  <= 1'b0;
         tx_cnt   <= '0;
         tx_bits  <= '0;
      end else if (!tx_busy) begin
         if (tx_start) begin
            tx_shift <= {1'b1, tx_data, 1'b0};
            tx_busy  <= 1'b1;
            tx_cnt   <= FULL_BIT;
            tx_bits  <= 4'd9;
         end
      end else if (tx_cnt == 0) begin
         tx_shift <= {1'b1, tx_shift[9:1]};
         tx_cnt   <= FULL_BIT;
         if (tx_bits == 0) tx_busy <= 1'b0;   // Stop bit done
         else tx_bits <= tx_bits - 1'b1;
      end else tx_cnt <= tx_cnt - 1'b1;
   end

   // The bridge must never start a byte on top of one in progress
   a_no_start_when_busy: assert property (@(posedge hba_clk) disable iff (hba_reset)
      !(tx_start && tx_busy));

endmodule

//--- design/hba_pkg.sv
// HBA bus package with the shared data, address and parser state types
`include "serial_fpga_consts.svh"

package hba_pkg;

   // One word on the read or write data bus
   typedef logic [`HBA_DBUS_WIDTH-1:0] hba_data_t;

   // Full address, peripheral index in the upper bits
   typedef logic [`HBA_ADDR_WIDTH-1:0] hba_addr_t;

   typedef logic [`HBA_PERIPH_ADDR_WIDTH-1:0] hba_periph_t; // Bank select
   typedef logic [`HBA_REG_ADDR_WIDTH-1:0]    hba_reg_t;    // Register within a bank

   // Command parser states of the bridge
   typedef enum logic [2:0] {
      IDLE,        // Ready for a command byte, rts high
      GET_ADDR,    // Waiting for the register address byte
      WRITE_DATA,  // Waiting for the next write data byte
      BUS_XFER,    // One bus transfer in flight
      SEND_DATA,   // Read byte ready, waiting on cts and the transmitter
      SEND_WAIT    // Read byte on the line
   } bridge_state_t;

endpackage

//--- include/serial_fpga_consts.svh
// Serial bridge constants for bus widths, bank and register counts, and the serial bit period
`ifndef SERIAL_FPGA_CONSTS_SVH
`define SERIAL_FPGA_CONSTS_SVH

// HBA data bus, one byte wide
`define HBA_DBUS_WIDTH 8

// Peripheral index selects one of the banks
`define HBA_PERIPH_ADDR_WIDTH 2

// Register index inside a bank
`define HBA_REG_ADDR_WIDTH 4

// Full bus address, peripheral index on top
`define HBA_ADDR_WIDTH (`HBA_PERIPH_ADDR_WIDTH + `HBA_REG_ADDR_WIDTH)

`define HBA_NUM_PERIPH 4                      // Banks on the bus

`define HBA_NUM_REGS (1 << `HBA_REG_ADDR_WIDTH) // Byte registers per bank

// Clocks per serial bit, shared with the host model
`define SERIAL_CLKS_PER_BIT 8

`endif
